//--- axil_crossbar.f
+incdir+design
design/axil_pkg.sv
design/axil_arbiter.sv
design/axil_register_bank.sv
design/axil_response_router.sv
design/axil_crossbar.sv
sim/axil_crossbar_tb.sv

//--- sim/axil_crossbar_tb.sv
// ==========================================================================
// AXI4-Lite crossbar testbench
// Table of master operations checked against a register shadow model
// ==========================================================================
`timescale 1ns/1ps
`include "axil_crossbar_settings.svh"

module axil_crossbar_tb
    import axil_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 40;

    // One table row per bus operation
    typedef struct packed {
        logic       master;
        logic       is_write;
        logic       with_next;
        logic       rnd;
        axil_addr_t addr;
        axil_data_t data;
        logic [3:0] delay;
        axil_resp_t resp;
    } op_t;

    logic                      clock;
    logic                      arst_n;
    axil_req_t  [`AXIL_NM-1:0] m_req;
    axil_rsp_t  [`AXIL_NM-1:0] m_rsp;
    bank_regs_t [`AXIL_NS-1:0] status_regs;
    bank_regs_t [`AXIL_NS-1:0] ctrl_regs;

    op_t         op_table [32];
    int          num_ops;
    axil_data_t  ctrl_shadow [`AXIL_NS][`AXIL_N_REGS];
    logic [31:0] rng_state;
    int          error_count;
    int          fail_count;
    int          first_accept;
    logic        timed_out;

    axil_crossbar axil_crossbar_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .m_req       (m_req),
        .m_rsp       (m_rsp),
        .status_regs (status_regs),
        .ctrl_regs   (ctrl_regs)
    );

    always #20 clock = ~clock;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Bank number from the address map or -1 on a miss
    function automatic int bank_of(input axil_addr_t addr);
        if ((addr & `AXIL_BANK_MASK) == `AXIL_BANK0_BASE) begin
            return 0;
        end else if ((addr & `AXIL_BANK_MASK) == `AXIL_BANK1_BASE) begin
            return 1;
        end
        return -1;
    endfunction

    task automatic add_op(input int master, input int is_write, input int with_next,
                          input int rnd, input axil_addr_t addr, input axil_data_t data,
                          input int delay, input axil_resp_t resp);
        op_table[num_ops] = '{master[0], is_write[0], with_next[0], rnd[0], addr, data,
                              delay[3:0], resp};
        num_ops++;
    endtask

    task automatic check_value(input int n, input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int errs);
        if (got !== exp) begin
            $display("CHECK FAILED test %0d: %s got %h expected %h", n, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_ctrl(input int n, inout int errs);
        for (int b = 0; b < `AXIL_NS; b++) begin
            for (int r = 0; r < `AXIL_N_REGS; r++) begin
                check_value(n, $sformatf("ctrl_regs[%0d][%0d]", b, r), ctrl_regs[b][r],
                            ctrl_shadow[b][r], errs);
            end
        end
    endtask

    task automatic report_timeout(input int n, input int m, input string what);
        $display("TIMEOUT test %0d: master %0d never saw %s", n, m, what);
        timed_out = 1'b1;
        error_count++;
        fail_count++;
    endtask

    // Accept (kind 0) or response valid (kind 1)
    // Cycles is -1 on a timeout
    task automatic wait_handshake(input int m, input logic is_write, input int kind,
                                  output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
            if (kind == 0) begin
                seen = is_write ? (m_rsp[m].aw_ready && m_rsp[m].w_ready) : m_rsp[m].ar_ready;
            end else begin
                seen = is_write ? m_rsp[m].b_valid : m_rsp[m].r_valid;
            end
        end
        if (!seen) begin
            cycles = -1;
        end
    endtask

    task automatic run_op(input int n);
        op_t        op;
        int         m;
        int         b;
        int         idx;
        int         errs;
        int         cycles;
        string      ch;
        axil_resp_t got_resp;
        axil_data_t got_data;
        axil_data_t exp_data;
        op   = op_table[n];
        m    = op.master;
        b    = bank_of(op.addr);
        idx  = op.addr[3:2];
        errs = 0;
        ch   = op.is_write ? "b" : "r";
        @(posedge clock);
        m_req[m].aw_valid <= op.is_write;
        m_req[m].w_valid  <= op.is_write;
        m_req[m].ar_valid <= !op.is_write;
        m_req[m].aw_addr  <= op.addr;
        m_req[m].ar_addr  <= op.addr;
        m_req[m].w_data   <= op.data;
        wait_handshake(m, op.is_write, 0, cycles);
        if (cycles < 0) begin
            report_timeout(n, m, "its accept");
            return;
        end
        if (first_accept < 0) begin
            first_accept = m;
        end
        @(posedge clock);
        m_req[m].aw_valid <= 1'b0;
        m_req[m].w_valid  <= 1'b0;
        m_req[m].ar_valid <= 1'b0;
        wait_handshake(m, op.is_write, 1, cycles);
        if (cycles < 0) begin
            report_timeout(n, m, $sformatf("%s_valid", ch));
            return;
        end
        // Two cycles from accept to response and one on a decode miss
        check_value(n, $sformatf("m_rsp[%0d].%s_valid delay", m, ch), cycles,
                    (b < 0) ? 1 : 2, errs);
        got_resp = op.is_write ? m_rsp[m].b_resp : m_rsp[m].r_resp;
        got_data = m_rsp[m].r_data;
        exp_data = '0;
        if (b >= 0 && idx < `AXIL_N_REGS) begin
            if (op.is_write) begin
                ctrl_shadow[b][idx] = op.data;
            end else begin
                exp_data = status_regs[b][idx];
            end
        end
        check_value(n, $sformatf("m_rsp[%0d].%s_resp", m, ch), got_resp, op.resp, errs);
        if (!op.is_write) begin
            check_value(n, $sformatf("m_rsp[%0d].r_data", m), got_data, exp_data, errs);
        end
        check_ctrl(n, errs);
        // Response held under back-pressure while the other master waits
        for (int d = 0; d < op.delay; d++) begin
            @(negedge clock);
            check_value(n, $sformatf("m_rsp[%0d].%s_valid", m, ch),
                        op.is_write ? m_rsp[m].b_valid : m_rsp[m].r_valid, 1, errs);
            check_value(n, $sformatf("m_rsp[%0d].%s_resp", m, ch),
                        op.is_write ? m_rsp[m].b_resp : m_rsp[m].r_resp, got_resp, errs);
            if (!op.is_write) begin
                check_value(n, $sformatf("m_rsp[%0d].r_data", m), m_rsp[m].r_data,
                            got_data, errs);
            end
            check_value(n, $sformatf("m_rsp[%0d].aw_ready|ar_ready", 1 - m),
                        m_rsp[1 - m].aw_ready || m_rsp[1 - m].ar_ready, 0, errs);
        end
        @(posedge clock);
        m_req[m].b_ready <= op.is_write;
        m_req[m].r_ready <= !op.is_write;
        @(posedge clock);
        m_req[m].b_ready <= 1'b0;
        m_req[m].r_ready <= 1'b0;
        error_count += errs;
        if (errs != 0) begin
            fail_count++;
        end
        $display("test %2d  master %0d  %s %h  %s", n, m, op.is_write ? "write" : "read ",
                 op.addr, (errs == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        int i;
        clock        = 1'b0;
        arst_n       = 1'b0;
        m_req        = '0;
        rng_state    = 32'd53544;
        num_ops      = 0;
        error_count  = 0;
        fail_count   = 0;
        first_accept = -1;
        timed_out    = 1'b0;
        for (int b = 0; b < `AXIL_NS; b++) begin
            for (int r = 0; r < `AXIL_N_REGS; r++) begin
                status_regs[b][r] = next_random();
                ctrl_shadow[b][r] = '0;
            end
        end

        // master, write, with next, random, address, data, ready delay, response
        add_op(0, 1, 1, 0, 32'h0000_0000, 32'h1111_0000, 0, RESP_OKAY);
        add_op(1, 1, 0, 0, 32'h2000_0004, 32'h2222_0001, 0, RESP_OKAY);
        add_op(1, 1, 0, 1, 32'h0000_0008, 32'h0, 0, RESP_OKAY);
        add_op(0, 1, 0, 1, 32'h2000_0000, 32'h0, 1, RESP_OKAY);
        add_op(0, 1, 0, 1, 32'h0000_0004, 32'h0, 3, RESP_OKAY);
        add_op(1, 1, 0, 1, 32'h2000_0008, 32'h0, 0, RESP_OKAY);
        add_op(0, 0, 0, 0, 32'h0000_0000, 32'h0, 0, RESP_OKAY);
        add_op(1, 0, 0, 0, 32'h2000_0004, 32'h0, 2, RESP_OKAY);
        add_op(0, 0, 0, 0, 32'h2000_0008, 32'h0, 0, RESP_OKAY);
        add_op(1, 0, 0, 0, 32'h0000_0008, 32'h0, 0, RESP_OKAY);
        add_op(0, 1, 0, 1, 32'h4000_0000, 32'h0, 0, RESP_DECERR);
        add_op(1, 0, 0, 0, 32'h8000_0004, 32'h0, 2, RESP_DECERR);
        add_op(0, 1, 0, 1, 32'h0000_000C, 32'h0, 0, RESP_SLVERR);
        add_op(1, 1, 0, 1, 32'h2000_000C, 32'h0, 1, RESP_SLVERR);
        add_op(1, 0, 0, 0, 32'h0000_000C, 32'h0, 0, RESP_SLVERR);
        add_op(0, 1, 1, 1, 32'h0000_0000, 32'h0, 6, RESP_OKAY);
        add_op(1, 0, 0, 0, 32'h2000_0000, 32'h0, 0, RESP_OKAY);
        add_op(0, 0, 1, 0, 32'h1000_0000, 32'h0, 4, RESP_DECERR);
        add_op(1, 1, 0, 1, 32'h2000_0004, 32'h0, 0, RESP_OKAY);
        for (int k = 0; k < num_ops; k++) begin
            if (op_table[k].rnd) begin
                op_table[k].data = next_random();
            end
        end

        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
        i = 0;
        while (i < num_ops && !timed_out) begin
            if (op_table[i].with_next) begin
                // Both masters raise their requests in the same cycle
                fork
                    run_op(i);
                    run_op(i + 1);
                join
                i += 2;
            end else begin
                run_op(i);
                i++;
            end
        end

        if (first_accept != 0) begin
            $display("CHECK FAILED first grant: master got %h expected %h", first_accept, 0);
            error_count++;
            fail_count++;
        end
        $display("test %2d  first grant after reset  %s", num_ops,
                 (first_accept == 0) ? "ok" : "FAILED");
        $display("%0d tests, %0d failed, %0d errors", num_ops + 1, fail_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- design/axil_crossbar.sv
// ==========================================================================
// AXI4-Lite shared interconnect
// Two masters reach the register banks through one arbiter
// ==========================================================================
`timescale 1ns/1ps
`include "axil_crossbar_settings.svh"

module axil_crossbar
    import axil_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  axil_req_t  [`AXIL_NM-1:0] m_req,
    output axil_rsp_t  [`AXIL_NM-1:0] m_rsp,
    input  bank_regs_t [`AXIL_NS-1:0] status_regs,
    output bank_regs_t [`AXIL_NS-1:0] ctrl_regs
);

    axil_req_t [`AXIL_NS-1:0] bank_req;
    axil_rsp_t [`AXIL_NS-1:0] bank_rsp;
    axil_rsp_t [`AXIL_NM-1:0] accept_rsp;
    bank_sel_t                grant;
    bank_sel_t                target;
    logic                     decode_miss;
    logic                     busy;
    logic                     done;

    axil_arbiter axil_arbiter_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .m_req       (m_req),
        .accept_rsp  (accept_rsp),
        .bank_req    (bank_req),
        .grant       (grant),
        .target      (target),
        .decode_miss (decode_miss),
        .busy        (busy),
        .done        (done)
    );

    // Identical banks, one per address window
    for (genvar s = 0; s < `AXIL_NS; s++) begin : g_bank
        axil_register_bank axil_register_bank_inst (
            .clock       (clock),
            .arst_n      (arst_n),
            .req         (bank_req[s]),
            .rsp         (bank_rsp[s]),
            .status_regs (status_regs[s]),
            .ctrl_regs   (ctrl_regs[s])
        );
    end

    axil_response_router axil_response_router_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .bank_rsp    (bank_rsp),
        .accept_rsp  (accept_rsp),
        .m_req       (m_req),
        .grant       (grant),
        .target      (target),
        .decode_miss (decode_miss),
        .busy        (busy),
        .m_rsp       (m_rsp),
        .done        (done)
    );

endmodule

//--- design/axil_response_router.sv
// ==========================================================================
// AXI4-Lite response router
// Returns the addressed bank's response, or DECERR, to the granted master
// ==========================================================================
`timescale 1ns/1ps
`include "axil_crossbar_settings.svh"

module axil_response_router
    import axil_pkg::*;
(
    input  logic                     clock,
    input  logic                     arst_n,
    input  axil_rsp_t [`AXIL_NS-1:0] bank_rsp,
    input  axil_rsp_t [`AXIL_NM-1:0] accept_rsp,
    input  axil_req_t [`AXIL_NM-1:0] m_req,
    input  bank_sel_t                grant,
    input  bank_sel_t                target,
    input  logic                     decode_miss,
    input  logic                     busy,
    output axil_rsp_t [`AXIL_NM-1:0] m_rsp,
    output logic                     done
);

    logic dec_b_valid;
    logic dec_r_valid;

    // DECERR starts on the accept handshake of a missed address
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dec_b_valid <= 1'b0;
            dec_r_valid <= 1'b0;
        end else if (decode_miss && accept_rsp[grant].aw_ready) begin
            dec_b_valid <= 1'b1;
        end else if (decode_miss && accept_rsp[grant].ar_ready) begin
            dec_r_valid <= 1'b1;
        end else if (done) begin
            dec_b_valid <= 1'b0;
            dec_r_valid <= 1'b0;
        end
    end

    always_comb begin
        for (int i = 0; i < `AXIL_NM; i++) begin
            m_rsp[i]          = '0;
            m_rsp[i].aw_ready = accept_rsp[i].aw_ready;
            m_rsp[i].w_ready  = accept_rsp[i].w_ready;
            m_rsp[i].ar_ready = accept_rsp[i].ar_ready;
            if (busy && grant == bank_sel_t'(i)) begin
                if (decode_miss) begin
                    m_rsp[i].b_valid = dec_b_valid;
                    m_rsp[i].b_resp  = RESP_DECERR;
                    m_rsp[i].r_valid = dec_r_valid;
                    m_rsp[i].r_resp  = RESP_DECERR;
                end else begin
                    m_rsp[i].b_valid = bank_rsp[target].b_valid;
                    m_rsp[i].b_resp  = bank_rsp[target].b_resp;
                    m_rsp[i].r_valid = bank_rsp[target].r_valid;
                    m_rsp[i].r_data  = bank_rsp[target].r_data;
                    m_rsp[i].r_resp  = bank_rsp[target].r_resp;
                end
            end
        end
    end

    // Completing b or r handshake ends the transaction
    assign done = busy &&
                  ((m_rsp[grant].b_valid && m_req[grant].b_ready) ||
                   (m_rsp[grant].r_valid && m_req[grant].r_ready));

endmodule

//--- design/axil_register_bank.sv
// ==========================================================================
// AXI4-Lite register bank
// Writable control registers driving outputs, readable status inputs
// ==========================================================================
`timescale 1ns/1ps
`include "axil_crossbar_settings.svh"

module axil_register_bank
    import axil_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  axil_req_t  req,
    output axil_rsp_t  rsp,
    input  bank_regs_t status_regs,
    output bank_regs_t ctrl_regs
);

    logic       b_valid;
    logic       r_valid;
    axil_resp_t b_resp;
    axil_resp_t r_resp;
    axil_data_t r_data;
    logic       idle;
    reg_idx_t   wr_idx;
    reg_idx_t   rd_idx;
    logic       wr_fire;
    logic       rd_fire;
    logic       wr_in_range;
    logic       rd_in_range;

    // Ready only while no response is pending
    assign idle = !b_valid && !r_valid;

    assign wr_idx      = req.aw_addr[3:2];
    assign rd_idx      = req.ar_addr[3:2];
    assign wr_in_range = (wr_idx < `AXIL_N_REGS);
    assign rd_in_range = (rd_idx < `AXIL_N_REGS);

    assign wr_fire = idle && req.aw_valid && req.w_valid;
    assign rd_fire = idle && req.ar_valid && !wr_fire;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_regs <= '0;
            b_valid   <= 1'b0;
            r_valid   <= 1'b0;
        end else begin
            if (wr_fire) begin
                b_valid <= 1'b1;
                if (wr_in_range) begin
                    ctrl_regs[wr_idx] <= req.w_data;
                end
            end else if (b_valid && req.b_ready) begin
                b_valid <= 1'b0;
            end

            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_valid && req.r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Response payload, held until the handshake
    always_ff @(posedge clock) begin
        if (wr_fire) begin
            b_resp <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            r_resp <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
            r_data <= rd_in_range ? status_regs[rd_idx] : '0;
        end
    end

    always_comb begin
        rsp          = '0;
        rsp.aw_ready = idle;
        rsp.w_ready  = idle;
        rsp.ar_ready = idle;
        rsp.b_valid  = b_valid;
        rsp.b_resp   = b_resp;
        rsp.r_valid  = r_valid;
        rsp.r_data   = r_data;
        rsp.r_resp   = r_resp;
    end

endmodule

//--- design/axil_arbiter.sv
// ==========================================================================
// AXI4-Lite arbiter
// Round-robin master pick, address decode, one transaction to one bank
// ==========================================================================
`timescale 1ns/1ps
`include "axil_crossbar_settings.svh"

module axil_arbiter
    import axil_pkg::*;
(
    input  logic                       clock,
    input  logic                       arst_n,
    input  axil_req_t [`AXIL_NM-1:0]   m_req,
    output axil_rsp_t [`AXIL_NM-1:0]   accept_rsp,
    output axil_req_t [`AXIL_NS-1:0]   bank_req,
    output bank_sel_t                  grant,
    output bank_sel_t                  target,
    output logic                       decode_miss,
    output logic                       busy,
    input  logic                       done
);

    localparam axil_addr_t [`AXIL_NS-1:0] BANK_BASE = {`AXIL_BANK1_BASE, `AXIL_BANK0_BASE};

    arb_state_t state;
    logic       acc_pend;
    logic       is_write;
    bank_sel_t  rr_ptr;
    axil_addr_t addr_q;
    axil_data_t data_q;

    logic [`AXIL_NM-1:0] master_pending;
    logic [`AXIL_NM-1:0] master_write;
    logic                pick_valid;
    bank_sel_t           pick_master;
    axil_addr_t          pick_addr;
    bank_sel_t           pick_target;
    logic                pick_miss;
    logic                pick_take;

    // A write needs both address and data valid together
    always_comb begin
        for (int i = 0; i < `AXIL_NM; i++) begin
            master_write[i]   = m_req[i].aw_valid && m_req[i].w_valid;
            master_pending[i] = master_write[i] || m_req[i].ar_valid;
        end
    end

    // Round robin, starting at the master after the last grant
    always_comb begin
        int idx;
        pick_valid  = 1'b0;
        pick_master = '0;
        for (int k = 0; k < `AXIL_NM; k++) begin
            idx = (int'(rr_ptr) + k) % `AXIL_NM;
            if (!pick_valid && master_pending[idx]) begin
                pick_valid  = 1'b1;
                pick_master = bank_sel_t'(idx);
            end
        end
    end

    assign pick_addr = master_write[pick_master] ? m_req[pick_master].aw_addr
                                                 : m_req[pick_master].ar_addr;

    // Address decode against base and mask
    always_comb begin
        pick_miss   = 1'b1;
        pick_target = '0;
        for (int s = 0; s < `AXIL_NS; s++) begin
            if (pick_miss && ((pick_addr & `AXIL_BANK_MASK) ==
                              (BANK_BASE[s] & `AXIL_BANK_MASK))) begin
                pick_miss   = 1'b0;
                pick_target = bank_sel_t'(s);
            end
        end
    end

    assign pick_take = (state == ARB_IDLE) && !acc_pend && pick_valid;
    assign busy      = (state != ARB_IDLE);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ARB_IDLE;
            acc_pend    <= 1'b0;
            rr_ptr      <= '0;
            grant       <= '0;
            target      <= '0;
            decode_miss <= 1'b0;
            is_write    <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (acc_pend) begin
                        acc_pend <= 1'b0;
                        state    <= ARB_ISSUE;
                    end else if (pick_take) begin
                        acc_pend    <= 1'b1;
                        grant       <= pick_master;
                        is_write    <= master_write[pick_master];
                        target      <= pick_target;
                        decode_miss <= pick_miss;
                        rr_ptr      <= bank_sel_t'((int'(pick_master) + 1) % `AXIL_NM);
                    end
                end
                // Only a decode miss can finish here
                ARB_ISSUE: state <= done ? ARB_IDLE : ARB_RESP;
                ARB_RESP: begin
                    if (done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (pick_take) begin
            addr_q <= pick_addr;
            data_q <= m_req[pick_master].w_data;
        end
    end

    // One-cycle accept pulse to the granted master
    always_comb begin
        for (int i = 0; i < `AXIL_NM; i++) begin
            accept_rsp[i]          = '0;
            accept_rsp[i].aw_ready = acc_pend && (grant == bank_sel_t'(i)) && is_write;
            accept_rsp[i].w_ready  = acc_pend && (grant == bank_sel_t'(i)) && is_write;
            accept_rsp[i].ar_ready = acc_pend && (grant == bank_sel_t'(i)) && !is_write;
        end
    end

    // Valid to the target bank in the issue cycle, readies while busy
    always_comb begin
        for (int s = 0; s < `AXIL_NS; s++) begin
            bank_req[s]         = '0;
            bank_req[s].aw_addr = addr_q;
            bank_req[s].ar_addr = addr_q;
            bank_req[s].w_data  = data_q;
            if (target == bank_sel_t'(s) && !decode_miss) begin
                bank_req[s].aw_valid = (state == ARB_ISSUE) && is_write;
                bank_req[s].w_valid  = (state == ARB_ISSUE) && is_write;
                bank_req[s].ar_valid = (state == ARB_ISSUE) && !is_write;
                bank_req[s].b_ready  = busy && m_req[grant].b_ready;
                bank_req[s].r_ready  = busy && m_req[grant].r_ready;
            end
        end
    end

endmodule

//--- design/axil_pkg.sv
// ==========================================================================
// AXI4-Lite crossbar package
// Bus vector types, request and response structs, arbiter states
// ==========================================================================
`include "axil_crossbar_settings.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

    // AXI response codes
    typedef logic [1:0] axil_resp_t;
    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;
    localparam axil_resp_t RESP_DECERR = 2'b11;

    // Register index from address bits 3:2
    typedef logic [1:0] reg_idx_t;

    // Bank number, also wide enough for a master number
    typedef logic [$clog2(`AXIL_NS)-1:0] bank_sel_t;

    // Master to slave direction
    typedef struct packed {
        logic       aw_valid;
        axil_addr_t aw_addr;
        logic       w_valid;
        axil_data_t w_data;
        logic       b_ready;
        logic       ar_valid;
        axil_addr_t ar_addr;
        logic       r_ready;
    } axil_req_t;

    // Slave to master direction
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        axil_resp_t b_resp;
        logic       ar_ready;
        logic       r_valid;
        axil_data_t r_data;
        axil_resp_t r_resp;
    } axil_rsp_t;

    typedef axil_data_t [`AXIL_N_REGS-1:0] bank_regs_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_RESP
    } arb_state_t;

endpackage

//--- design/axil_crossbar_settings.svh
// ==========================================================================
// AXI4-Lite crossbar settings
// Master and bank counts, bus widths, register count and bank address map
// ==========================================================================
`ifndef AXIL_CROSSBAR_SETTINGS_SVH
`define AXIL_CROSSBAR_SETTINGS_SVH

// Bus masters and register banks
`define AXIL_NM 2
`define AXIL_NS 2

// Bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Control and status registers per bank
`define AXIL_N_REGS 3

// Bank address map, one mask for both banks
`define AXIL_BANK0_BASE 32'h0000_0000
`define AXIL_BANK1_BASE 32'h2000_0000
`define AXIL_BANK_MASK  32'hF000_0000

`endif
